//--- verilog/deck_params.svh
/*
 * Deck engine constants
 * Deck size, card field widths, pile index width
 * and the pile count that switches inserts to random placement
 */
`ifndef DECK_PARAMS_SVH
`define DECK_PARAMS_SVH

// Full standard deck, 27 cards per colour
`define DECK_SIZE 108

// Card word is colour on top of value
`define CARD_W  6
`define COLOR_W 2
`define VALUE_W 4

`define IDX_W 7 // Pile position or count, also the LFSR width

// Below this count an insert just lands on top
`define INSERT_RAND_MIN 20

`endif

//--- verilog/deck_pkg.sv
/*
 * Shared types for the deck engine
 * Card and index typedefs, pile and arbiter FSM encodings,
 * std_card lookup of the ordered deck
 */
`default_nettype none

`include "deck_params.svh"

package deck_pkg;

    typedef logic [`CARD_W-1:0]  card_t;    // {colour, value}
    typedef logic [`COLOR_W-1:0] color_t;   // 0 red, 1 yellow, 2 green, 3 blue
    typedef logic [`VALUE_W-1:0] value_t;   // 0-9, 10 skip, 11 rev, 12 +2, 13 wild, 14 wild +4
    typedef logic [`IDX_W-1:0]   pile_idx_t;
    typedef logic [2:0]          draw_cnt_t; // Cards per draw, 0 is no draw

    typedef enum logic [1:0] {
        P_IDLE,
        P_SHUFFLE, // Fisher-Yates walk
        P_INSERT   // Waiting for a usable random slot
    } pile_state_e;

    typedef enum logic [1:0] {
        A_IDLE,
        A_DRAW,    // Pop one card or swap piles
        A_GAP      // One spare cycle so the pile count settles
    } arb_state_e;

    // Card at a position of the unshuffled deck
    function automatic card_t std_card(input pile_idx_t pos);
        color_t    color;
        value_t    value;
        pile_idx_t rank;
        color = color_t'(pos / (`DECK_SIZE / 4));
        rank  = pile_idx_t'(pos % (`DECK_SIZE / 4)); // Slot inside the colour block
        if (rank == 0) begin
            value = '0; // Single zero
        end else if (rank <= 18) begin
            value = value_t'((rank + 1) / 2); // 1 to 9, two of each
        end else if (rank <= 24) begin
            value = value_t'(10 + (rank - 19) / 2); // Action cards in pairs
        end else if (rank == 25) begin
            value = value_t'(13);
        end else begin
            value = value_t'(14);
        end
        return {color, value};
    endfunction

endpackage

`default_nettype wire

//--- verilog/card_lfsr.sv
/*
 * Random position source
 * Free-running seed counter, 7-bit Fibonacci LFSR
 */
`timescale 1ns/1ps
`default_nettype none

`include "deck_params.svh"

module card_lfsr (
    input  wire                 i_clk,
    input  wire                 i_rst_n,
    input  wire                 i_seed,  // Reload LFSR from the counter
    output deck_pkg::pile_idx_t o_rand   // 0 to 126
);

    logic [`IDX_W-1:0] cnt_r;  // Seed timer, runs since reset
    logic [`IDX_W-1:0] lfsr_r;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            cnt_r  <= '0;
            lfsr_r <= `IDX_W'd1; // Any nonzero start
        end else begin
            cnt_r <= cnt_r + 1'b1;
            if (i_seed) begin
                lfsr_r <= {cnt_r[`IDX_W-1:1], 1'b1}; // Bit 0 set, never all zero
            end else begin
                lfsr_r <= {lfsr_r[3] ^ lfsr_r[0], lfsr_r[`IDX_W-1:1]}; // Shift right
            end
        end
    end

    // State is 1..127, so minus one covers 0..126
    assign o_rand = deck_pkg::pile_idx_t'(lfsr_r - 1'b1);

endmodule

`default_nettype wire

//--- verilog/card_pile.sv
/*
 * One card pile with its count
 * Pop from top, Fisher-Yates shuffle and threshold insert,
 * both random loops retry until the LFSR gives a slot in range
 */
`timescale 1ns/1ps
`default_nettype none

`include "deck_params.svh"

module card_pile #(
    parameter int PRESET = 0 // 1 loads the ordered deck at reset
) (
    input  wire                 i_clk,
    input  wire                 i_rst_n,
    input  wire                 i_pop,
    input  wire                 i_shuffle,
    input  wire                 i_insert,
    input  deck_pkg::card_t     i_card,
    input  deck_pkg::pile_idx_t i_rand,
    output deck_pkg::card_t     o_top,
    output deck_pkg::pile_idx_t o_count,
    output logic                o_busy
);

    deck_pkg::card_t     mem [`DECK_SIZE]; // Position 0 is the bottom
    deck_pkg::pile_idx_t count_r;
    deck_pkg::pile_idx_t k_r;               // Shuffle walk position
    deck_pkg::pile_idx_t top_idx;
    deck_pkg::card_t     ins_card_r;        // Card held while a random slot is found
    deck_pkg::pile_state_e state_r;

    logic ins_direct; // Small pile, card goes straight on top
    logic ins_start;
    logic shuf_swap;
    logic ins_place;

    assign top_idx = count_r - 1'b1;

    assign ins_direct = (state_r == deck_pkg::P_IDLE) && !i_shuffle && i_insert
                        && (count_r < `INSERT_RAND_MIN);
    assign ins_start  = (state_r == deck_pkg::P_IDLE) && !i_shuffle && i_insert
                        && (count_r >= `INSERT_RAND_MIN) && (count_r < `DECK_SIZE);
    assign shuf_swap  = (state_r == deck_pkg::P_SHUFFLE) && (i_rand <= k_r);
    assign ins_place  = (state_r == deck_pkg::P_INSERT) && (i_rand <= top_idx);

    // Card storage, preset pile comes up as the ordered deck
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 0; i < `DECK_SIZE; i++) begin
                mem[i] <= (PRESET != 0) ? deck_pkg::std_card(deck_pkg::pile_idx_t'(i)) : '0;
            end
        end else if (ins_direct) begin
            mem[count_r] <= i_card;
        end else if (shuf_swap) begin
            mem[k_r]    <= mem[i_rand]; // Swap k with the drawn slot
            mem[i_rand] <= mem[k_r];
        end else if (ins_place) begin
            mem[count_r] <= mem[i_rand]; // Displaced card moves to the top
            mem[i_rand]  <= ins_card_r;
        end
    end

    always_ff @(posedge i_clk) begin
        if (ins_start) begin
            ins_card_r <= i_card;
        end
    end

    // Pile FSM and count
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_r <= deck_pkg::P_IDLE;
            count_r <= (PRESET != 0) ? deck_pkg::pile_idx_t'(`DECK_SIZE) : '0;
            k_r     <= '0;
        end else begin
            case (state_r)
                deck_pkg::P_IDLE: begin
                    if (i_shuffle) begin
                        if (count_r >= 2) begin // Fewer than two cards, nothing to do
                            state_r <= deck_pkg::P_SHUFFLE;
                            k_r     <= top_idx;
                        end
                    end else if (ins_direct) begin
                        count_r <= count_r + 1'b1;
                    end else if (ins_start) begin
                        state_r <= deck_pkg::P_INSERT;
                    end else if (i_pop && (count_r != 0)) begin
                        count_r <= top_idx;
                    end
                end
                deck_pkg::P_SHUFFLE: begin
                    if (shuf_swap) begin // Otherwise retry next cycle
                        k_r <= k_r - 1'b1;
                        if (k_r == deck_pkg::pile_idx_t'(1)) begin
                            state_r <= deck_pkg::P_IDLE; // Slot 0 needs no swap
                        end
                    end
                end
                deck_pkg::P_INSERT: begin
                    if (ins_place) begin
                        count_r <= count_r + 1'b1;
                        state_r <= deck_pkg::P_IDLE;
                    end
                end
                default: state_r <= deck_pkg::P_IDLE;
            endcase
        end
    end

    // Empty pile shows a zero card
    assign o_top   = (count_r == 0) ? '0 : mem[top_idx];
    assign o_count = count_r;
    assign o_busy  = (state_r != deck_pkg::P_IDLE);

endmodule

`default_nettype wire

//--- verilog/pile_arbiter.sv
/*
 * Pile arbiter
 * Active pile select, command routing,
 * multi-card draw sequencing with pile swap and early end
 */
`timescale 1ns/1ps
`default_nettype none

module pile_arbiter (
    input  wire                 i_clk,
    input  wire                 i_rst_n,
    input  wire                 i_start,
    input  wire                 i_insert,
    input  deck_pkg::card_t     i_prev_card,
    input  deck_pkg::draw_cnt_t i_draw,
    input  deck_pkg::card_t     i_top_a,
    input  deck_pkg::card_t     i_top_b,
    input  deck_pkg::pile_idx_t i_count_a,
    input  deck_pkg::pile_idx_t i_count_b,
    input  wire                 i_busy_a,
    input  wire                 i_busy_b,
    output logic                o_pop_a,
    output logic                o_pop_b,
    output logic                o_shuffle_a,
    output logic                o_shuffle_b,
    output logic                o_insert_a,
    output logic                o_insert_b,
    output deck_pkg::card_t     o_ins_card,
    output logic                o_done,
    output logic                o_drawn,
    output deck_pkg::card_t     o_card
);

    deck_pkg::arb_state_e state_r;
    deck_pkg::draw_cnt_t  left_r;   // Cards still owed to the current draw
    logic                 act_r;    // 0 pile A active, 1 pile B

    deck_pkg::pile_idx_t act_cnt;
    deck_pkg::pile_idx_t oth_cnt;
    logic cmd_start;
    logic cmd_insert;
    logic cmd_draw;
    logic drawing;

    assign o_done = (state_r == deck_pkg::A_IDLE) && !i_busy_a && !i_busy_b;

    // Start beats insert beats draw, all only while done
    assign cmd_start  = o_done && i_start;
    assign cmd_insert = o_done && !i_start && i_insert;
    assign cmd_draw   = o_done && !i_start && !i_insert && (i_draw != 0);

    assign act_cnt = act_r ? i_count_b : i_count_a;
    assign oth_cnt = act_r ? i_count_a : i_count_b;
    assign drawing = (state_r == deck_pkg::A_DRAW) && (act_cnt != 0);

    assign o_shuffle_a = cmd_start && !act_r;  // Shuffle hits the active pile
    assign o_shuffle_b = cmd_start && act_r;
    assign o_insert_a  = cmd_insert && act_r;  // Played card goes to the other pile
    assign o_insert_b  = cmd_insert && !act_r;
    assign o_ins_card  = i_prev_card;

    assign o_pop_a = drawing && !act_r;
    assign o_pop_b = drawing && act_r;
    assign o_drawn = drawing;
    assign o_card  = act_r ? i_top_b : i_top_a; // Top of the active pile

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_r <= deck_pkg::A_IDLE;
            left_r  <= '0;
            act_r   <= 1'b0;
        end else begin
            case (state_r)
                deck_pkg::A_IDLE: begin
                    if (cmd_draw) begin
                        left_r  <= i_draw;
                        state_r <= deck_pkg::A_DRAW;
                    end
                end
                deck_pkg::A_DRAW: begin
                    if (act_cnt != 0) begin
                        left_r  <= left_r - 1'b1;
                        state_r <= deck_pkg::A_GAP;
                    end else if (oth_cnt != 0) begin
                        act_r <= ~act_r; // Dry pile, swap roles and retry
                    end else begin
                        state_r <= deck_pkg::A_IDLE; // Both empty, end early
                    end
                end
                deck_pkg::A_GAP: begin
                    state_r <= (left_r == 0) ? deck_pkg::A_IDLE : deck_pkg::A_DRAW;
                end
                default: state_r <= deck_pkg::A_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- verilog/deck_top.sv
/*
 * Deck engine top level
 * Random source, draw and discard piles, arbiter
 */
`timescale 1ns/1ps
`default_nettype none

module deck_top (
    input  wire                 i_clk,
    input  wire                 i_rst_n,
    input  wire                 i_start,
    input  wire                 i_insert,
    input  deck_pkg::card_t     i_prev_card,
    input  deck_pkg::draw_cnt_t i_draw,
    output logic                o_done,
    output logic                o_drawn,
    output deck_pkg::card_t     o_card
);

    deck_pkg::pile_idx_t rand_pos;
    deck_pkg::card_t     top_a;
    deck_pkg::card_t     top_b;
    deck_pkg::card_t     ins_card;
    deck_pkg::pile_idx_t count_a;
    deck_pkg::pile_idx_t count_b;
    logic busy_a;
    logic busy_b;
    logic pop_a;
    logic pop_b;
    logic shuffle_a;
    logic shuffle_b;
    logic insert_a;
    logic insert_b;

    // Reseed only when the start is actually taken
    card_lfsr u_lfsr (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_seed  (i_start & o_done),
        .o_rand  (rand_pos)
    );

    // Pile A starts as the full draw pile
    card_pile #(.PRESET(1)) u_pile_a (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_pop     (pop_a),
        .i_shuffle (shuffle_a),
        .i_insert  (insert_a),
        .i_card    (ins_card),
        .i_rand    (rand_pos),
        .o_top     (top_a),
        .o_count   (count_a),
        .o_busy    (busy_a)
    );

    card_pile #(.PRESET(0)) u_pile_b ( // Empty discard pile
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_pop     (pop_b),
        .i_shuffle (shuffle_b),
        .i_insert  (insert_b),
        .i_card    (ins_card),
        .i_rand    (rand_pos),
        .o_top     (top_b),
        .o_count   (count_b),
        .o_busy    (busy_b)
    );

    pile_arbiter u_arb (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_start     (i_start),
        .i_insert    (i_insert),
        .i_prev_card (i_prev_card),
        .i_draw      (i_draw),
        .i_top_a     (top_a),
        .i_top_b     (top_b),
        .i_count_a   (count_a),
        .i_count_b   (count_b),
        .i_busy_a    (busy_a),
        .i_busy_b    (busy_b),
        .o_pop_a     (pop_a),
        .o_pop_b     (pop_b),
        .o_shuffle_a (shuffle_a),
        .o_shuffle_b (shuffle_b),
        .o_insert_a  (insert_a),
        .o_insert_b  (insert_b),
        .o_ins_card  (ins_card),
        .o_done      (o_done),
        .o_drawn     (o_drawn),
        .o_card      (o_card)
    );

endmodule

`default_nettype wire

//--- bench/deck_tb.sv
/*
 * Self-checking testbench for the deck engine
 * Per-pile card multiset model, random draws, inserts and shuffles
 */
`timescale 1ns/1ps
`default_nettype none

`include "deck_params.svh"

module deck_tb;

    localparam int N_SWAP_INS = 30;  // Crosses the random insert threshold
    localparam int N_LAST_INS = 25;
    localparam int N_DRAWS    = 1 + 104 + N_SWAP_INS + 2 + N_LAST_INS + 1; // Worst case
    localparam int N_INSERTS  = N_SWAP_INS + N_LAST_INS + 1;
    localparam int N_SHUFFLES = 2;
    localparam int WATCHDOG_NS = (N_DRAWS + N_INSERTS + N_SHUFFLES) * 300 * 8;
    localparam int DONE_LIMIT = 20000; // Longest wait for o_done in cycles

    logic                i_clk;
    logic                i_rst_n;
    logic                i_start;
    logic                i_insert;
    deck_pkg::card_t     i_prev_card;
    deck_pkg::draw_cnt_t i_draw;
    logic                o_done;
    logic                o_drawn;
    deck_pkg::card_t     o_card;

    int mult [2][64];     // Expected card counts per pile
    int cnt [2];          // Expected pile sizes
    int act;              // Active pile in the model
    int seed = 32'h7599b111;
    int pulse_at [8];     // Cycle of each pulse in the last draw
    deck_pkg::card_t pulse_card [8];

    deck_top DUT (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_start     (i_start),
        .i_insert    (i_insert),
        .i_prev_card (i_prev_card),
        .i_draw      (i_draw),
        .o_done      (o_done),
        .o_drawn     (o_drawn),
        .o_card      (o_card)
    );

    initial begin
        i_clk = 1'b0;
        forever #4 i_clk = ~i_clk; // 8 ns period
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired before all tests completed");
        $display("Simulation FAILED");
        $fatal(1, "Run time limit reached");
    end

    task automatic compare_value(input string name, input logic [31:0] actual,
                                 input logic [31:0] expected);
        if (actual !== expected) begin
            $display("** Error: %s = 0x%0h, expected 0x%0h", name, actual, expected);
            $display("Simulation FAILED");
            $fatal(1, "Stopped at first mismatch");
        end
    endtask

    task automatic abort_on_timeout(input string what);
        $display("Timeout: %s", what);
        $display("Simulation FAILED");
        $fatal(1, "Stopped on timeout");
    endtask

    task automatic wait_done();
        int cyc;
        cyc = 0;
        while (!o_done) begin
            @(negedge i_clk);
            cyc++;
            if (cyc > DONE_LIMIT) abort_on_timeout("o_done never rose after a command");
        end
    endtask

    // Checks one drawn card against the model and swaps first when the active pile is dry
    task automatic take_card(input deck_pkg::card_t c);
        if (cnt[act] == 0) act = 1 - act;
        compare_value($sformatf("o_card 0x%0h value legal", c), c[3:0] <= 14, 1);
        compare_value($sformatf("o_card 0x%0h present in pile", c), mult[act][c] != 0, 1);
        mult[act][c]--;
        cnt[act]--;
    endtask

    // Called at a falling edge with o_done high
    task automatic draw_cards(input int n);
        int want;
        int got;
        int cyc;
        want = (n < cnt[0] + cnt[1]) ? n : cnt[0] + cnt[1];
        got  = 0;
        i_draw = deck_pkg::draw_cnt_t'(n);
        @(negedge i_clk);
        i_draw = '0;
        cyc = 1; // One cycle past the command edge
        while (!o_done) begin
            if (o_drawn) begin
                take_card(o_card);
                if (got < 8) begin
                    pulse_at[got]   = cyc;
                    pulse_card[got] = o_card;
                end
                got++;
            end
            if (cyc > DONE_LIMIT) abort_on_timeout("draw never finished");
            @(negedge i_clk);
            cyc++;
        end
        compare_value("o_drawn", o_drawn, 0);
        compare_value("o_drawn pulses per draw", got, want);
    endtask

    task automatic insert_card(input deck_pkg::card_t c);
        int dst;
        dst = 1 - act; // Played card lands on the inactive pile
        i_insert    = 1'b1;
        i_prev_card = c;
        @(negedge i_clk);
        i_insert = 1'b0;
        if (cnt[dst] < `INSERT_RAND_MIN) compare_value("o_done", o_done, 1); // Direct insert
        wait_done();
        mult[dst][c]++;
        cnt[dst]++;
    endtask

    task automatic shuffle_pile();
        i_start = 1'b1;
        @(negedge i_clk);
        i_start = 1'b0;
        wait_done();
    endtask

    function automatic deck_pkg::card_t random_card(input logic [31:0] r);
        return {r[5:4], 4'(r[31:8] % 15)}; // Any colour with a value from 0 to 14
    endfunction

    initial begin
        logic [31:0] rnd;
        i_rst_n     = 1'b0;
        i_start     = 1'b0;
        i_insert    = 1'b0;
        i_prev_card = '0;
        i_draw      = '0;
        act    = 0;
        cnt[0] = `DECK_SIZE;
        cnt[1] = 0;
        for (int c = 0; c < 64; c++) begin
            mult[0][c] = 0;
            mult[1][c] = 0;
        end
        for (int i = 0; i < `DECK_SIZE; i++) begin
            mult[0][deck_pkg::std_card(deck_pkg::pile_idx_t'(i))]++;
        end
        repeat (2) @(posedge i_clk);
        @(negedge i_clk);
        i_rst_n = 1'b1;
        @(negedge i_clk);

        // Top four cards of the ordered deck come out in reverse order
        compare_value("o_done", o_done, 1);
        compare_value("o_drawn", o_drawn, 0);
        draw_cards(4);
        for (int i = 0; i < 4; i++) begin
            compare_value("o_card", pulse_card[i], deck_pkg::std_card(
                          deck_pkg::pile_idx_t'(`DECK_SIZE - 1 - i)));
            compare_value("o_drawn cycle", pulse_at[i], 2 * i + 1);
        end

        // Shuffle the rest and drain it
        shuffle_pile();
        while (cnt[0] + cnt[1] > 0) begin
            rnd = $random(seed);
            draw_cards(1 + rnd[1:0]);
        end

        // Fill the discard pile past the threshold and draw through the swap
        for (int i = 0; i < N_SWAP_INS; i++) begin
            rnd = $random(seed);
            insert_card(random_card(rnd));
        end
        draw_cards(1); // Pile A is dry so one swap cycle comes first
        compare_value("o_drawn cycle after swap", pulse_at[0], 2);
        while (cnt[0] + cnt[1] > 0) begin
            rnd = $random(seed);
            draw_cards(1 + rnd[1:0]);
        end

        // Both piles empty
        draw_cards(3);

        // Commands while busy must be dropped
        for (int i = 0; i < N_LAST_INS; i++) begin
            rnd = $random(seed);
            insert_card(random_card(rnd));
        end
        draw_cards(1); // Swaps back to pile A and leaves 24 cards
        i_start = 1'b1;
        @(negedge i_clk);
        i_start = 1'b0;
        compare_value("o_done", o_done, 0); // Shuffle still running
        rnd = $random(seed);
        i_draw      = 3'd4;
        i_insert    = 1'b1;
        i_prev_card = random_card(rnd);
        @(negedge i_clk);
        i_draw   = '0;
        i_insert = 1'b0;
        wait_done();
        while (cnt[0] + cnt[1] > 0) begin
            draw_cards(4);
        end
        draw_cards(2); // Nothing may be left behind

        $display("Simulation PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+verilog
verilog/deck_pkg.sv
verilog/card_lfsr.sv
verilog/card_pile.sv
verilog/pile_arbiter.sv
verilog/deck_top.sv
bench/deck_tb.sv

//--- Bender.yml
package:
  name: card_deck_engine

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/deck_pkg.sv
      - verilog/card_lfsr.sv
      - verilog/card_pile.sv
      - verilog/pile_arbiter.sv
      - verilog/deck_top.sv
  - target: simulation
    include_dirs:
      - verilog
    files:
      - bench/deck_tb.sv
